//--- vlog.f
+incdir+include
src/simd_pkg.sv
src/simd_operand_prep.sv
src/simd_lane.sv
src/simd_latency_track.sv
src/simd_result_stage.sv
src/simd_exec_unit.sv
verif/tb_clock_gen.sv
verif/tb_simd_exec_unit.sv

//--- Makefile
# Verilator build and run of the SIMD execution unit testbench

SRCS = $(shell grep -v '^+' vlog.f) include/simd_tb_model.svh

obj_dir/Vtb_simd_exec_unit: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_simd_exec_unit -f vlog.f

run: obj_dir/Vtb_simd_exec_unit
	./obj_dir/Vtb_simd_exec_unit | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- include/simd_tb_model.svh
// Reference model of the SIMD unit: LCG step, latency, element ALU, vector and scalar results
`ifndef SIMD_TB_MODEL_SVH
`define SIMD_TB_MODEL_SVH

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic int sew_bits(input sew_e sew);
    return 8 << sew;
endfunction

function automatic logic [63:0] elem_mask(input int bits);
    return (bits == 64) ? 64'hffff_ffff_ffff_ffff : (64'h1 << bits) - 64'h1;
endfunction

// Cycles from the sampling edge to the writeback
function automatic int expected_latency(input simd_op_e op, input sew_e sew);
    if (op == OP_MUL) begin
        return (sew == SEW_64) ? 3 : 2;
    end
    return 1;
endfunction

function automatic logic [63:0] elem_alu(input simd_op_e op, input logic [63:0] a,
                                         input logic [63:0] b, input logic [63:0] m);
    case (op)
        OP_ADD:  return (a + b) & m;
        OP_SUB:  return (a - b) & m;
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        OP_MUL:  return (a * b) & m;  // Low half of the product
        default: return a;
    endcase
endfunction

function automatic logic [MAX_VLEN-1:0] vec_expect(input simd_req_t r, input int vlen);
    int                  bits;
    logic [63:0]         m;
    logic [63:0]         scal;
    logic [63:0]         b;
    logic [63:0]         res;
    logic [MAX_VLEN-1:0] wide;
    logic [MAX_VLEN-1:0] out;
    bits = sew_bits(r.sew);
    m    = elem_mask(bits);
    scal = (r.src == SRC_VI) ? {{59{r.imm5[4]}}, r.imm5} : r.rs1;
    out  = '0;
    for (int e = 0; e < vlen / bits; e++) begin
        b   = (r.src == SRC_VV) ? (r.vs1[e*bits +: 64] & m) : (scal & m);
        res = elem_alu(r.op, r.vs2[e*bits +: 64] & m, b, m);
        if (r.use_mask && !r.vm[e]) begin
            res = r.old_vd[e*bits +: 64] & m;  // Inactive element keeps old value
        end
        wide       = '0;
        wide[63:0] = res;
        out        = out | (wide << (e * bits));
    end
    return out;
endfunction

function automatic logic [63:0] scalar_expect(input simd_req_t r, input int vlen);
    int          bits;
    int          idx;
    logic [63:0] m;
    logic [63:0] e;
    bits = sew_bits(r.sew);
    m    = elem_mask(bits);
    if (r.op == OP_MV_X_S) begin
        e = r.vs2[63:0] & m;
        return e[bits-1] ? (e | ~m) : e;  // Sign-extend element 0
    end
    if (r.rs1 >= 64'(vlen / bits)) begin
        return 64'h0;
    end
    idx = int'(r.rs1[31:0]);
    return r.vs2[idx*bits +: 64] & m;
endfunction

`endif

//--- verif/tb_simd_exec_unit.sv
// Testbench top: random requests, reference model scoreboard, writeback checks and timeout
`timescale 1ns/1ps

module tb_simd_exec_unit
    import simd_pkg::*;
();

    localparam int          VLEN    = 128;
    localparam int          NUM_REQ = 600;
    localparam int          TIMEOUT = 4 * NUM_REQ + 100;
    localparam logic [31:0] SEED    = 32'hb69e_33f3;

    typedef struct packed {
        logic [31:0]         due;      // Cycle in which the writeback is expected
        logic                is_scalar;
        logic [4:0]          rd;
        simd_op_e            op;
        sew_e                sew;
        src_e                src;
        logic                use_mask;
        logic [63:0]         scalar;
        logic [MAX_VLEN-1:0] vec;
    } expect_t;

    logic        clk;
    logic        rstn;
    simd_req_t   req;
    scalar_wb_t  scalar_wb;
    vector_wb_t  vector_wb;

    logic [31:0] seed;
    logic [31:0] cyc        = '0;
    int          issued     = 0;
    int          skipped    = 0;
    int          checks     = 0;
    int          value_errs = 0;
    int          proto_errs = 0;
    expect_t     exp_q [$];

`include "simd_tb_model.svh"

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(16)) u_clock_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    simd_exec_unit #(.VLEN(VLEN)) uut (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .req_i       (req),
        .scalar_wb_o (scalar_wb),
        .vector_wb_o (vector_wb)
    );

    // High bits of an LCG are the better ones, so they come out low
    function automatic logic [31:0] next_rand();
        seed = lcg_step(seed);
        return {seed[15:0], seed[31:16]};
    endfunction

    function automatic bit due_taken(input logic [31:0] due);
        foreach (exp_q[i]) begin
            if (exp_q[i].due == due) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic string test_name(input expect_t e);
        simd_op_e op;
        src_e     src;
        op  = e.op;
        src = e.src;
        return $sformatf("%s/SEW%0d/%s%s", op.name(), 8 << e.sew, src.name(),
                         e.use_mask ? "/masked" : "");
    endfunction

    task automatic drive_request();
        simd_req_t   r;
        expect_t     e;
        logic [31:0] ctl;
        logic [31:0] ctl2;
        logic [31:0] due;
        r          = '0;
        ctl        = next_rand();
        ctl2       = next_rand();
        r.valid    = 1'b1;
        r.op       = simd_op_e'(ctl[2:0]);
        r.sew      = sew_e'(ctl[4:3]);
        r.src      = (ctl[6:5] == 2'd3) ? SRC_VV : src_e'(ctl[6:5]);
        if (r.op == OP_MUL && r.src == SRC_VI) begin
            r.src = SRC_VX;  // No multiply by immediate
        end
        r.use_mask = ctl[7];
        r.vd       = ctl[12:8];
        r.imm5     = ctl2[4:0];
        r.rs1      = {next_rand(), next_rand()};
        if (ctl2[5]) begin
            r.rs1 = 64'(ctl2[11:6]);  // Element index near the vext range limit
        end
        for (int w = 0; w < VLEN / 32; w++) begin
            r.vs1[w*32 +: 32]    = next_rand();
            r.vs2[w*32 +: 32]    = next_rand();
            r.vm[w*32 +: 32]     = next_rand();
            r.old_vd[w*32 +: 32] = next_rand();
        end
        due = cyc + 32'(expected_latency(r.op, r.sew));
        if (due_taken(due)) begin
            req = '0;
            skipped++;
        end else begin
            e.due       = due;
            e.is_scalar = (r.op == OP_MV_X_S) || (r.op == OP_EXT);
            e.rd        = r.vd;
            e.op        = r.op;
            e.sew       = r.sew;
            e.src       = r.src;
            e.use_mask  = r.use_mask;
            e.scalar    = scalar_expect(r, VLEN);
            e.vec       = vec_expect(r, VLEN);
            exp_q.push_back(e);
            req = r;
            issued++;
        end
    endtask

    task automatic check_outputs();
        int      hit;
        expect_t e;
        hit = -1;
        foreach (exp_q[i]) begin
            if (exp_q[i].due == cyc) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            if (scalar_wb.valid || vector_wb.valid) begin
                proto_errs++;
                $display("Writeback valid in cycle %0d while no request was due", cyc);
            end
        end else begin
            e = exp_q[hit];
            exp_q.delete(hit);
            checks++;
            if (scalar_wb.valid != e.is_scalar || vector_wb.valid == e.is_scalar) begin
                proto_errs++;
                $display("%s due in cycle %0d raised the wrong writeback valid",
                         test_name(e), cyc);
            end else if (e.is_scalar) begin
                if (scalar_wb.rd != e.rd || scalar_wb.result != e.scalar) begin
                    value_errs++;
                    $display("** Error %s: expected rd %0d %h, actual rd %0d %h", test_name(e),
                             e.rd, e.scalar, scalar_wb.rd, scalar_wb.result);
                end
            end else begin
                if (vector_wb.vd != e.rd || vector_wb.vresult != e.vec) begin
                    value_errs++;
                    $display("** Error %s: expected vd %0d %h, actual vd %0d %h", test_name(e),
                             e.rd, e.vec[VLEN-1:0], vector_wb.vd, vector_wb.vresult[VLEN-1:0]);
                end
            end
        end
    endtask

    task automatic report_counts();
        $display("Issued %0d, skipped %0d, checks %0d, value errors %0d, protocol errors %0d",
                 issued, skipped, checks, value_errs, proto_errs);
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 32'd1;
        if (cyc == 32'(TIMEOUT)) begin
            $display("Timeout after %0d cycles with %0d results outstanding", TIMEOUT,
                     exp_q.size());
            report_counts();
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        seed = SEED;
        req  = '0;
        wait (rstn === 1'b1);
        while (issued < NUM_REQ || exp_q.size() != 0) begin
            @(negedge clk);
            check_outputs();
            if (issued < NUM_REQ) begin
                drive_request();
            end else begin
                req = '0;
            end
        end
        repeat (4) begin  // Idle tail catches stray valids
            @(negedge clk);
            check_outputs();
        end
        report_counts();
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
// Testbench clock and active-low reset generator
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

//--- src/simd_exec_unit.sv
// Vector SIMD execution unit top level, instances and wiring
`timescale 1ns/1ps

module simd_exec_unit
    import simd_pkg::*;
#(
    parameter int VLEN = 128  // Multiple of 64, up to MAX_VLEN
) (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  simd_req_t  req_i,
    output scalar_wb_t scalar_wb_o,
    output vector_wb_t vector_wb_o
);

    localparam int LANES = VLEN / LANE_W;

    lane_op_t   [LANES-1:0] lane_ops;
    elem_word_u [LANES-1:0] lane_res;
    logic [1:0]             lat;
    simd_meta_t             meta;
    simd_meta_t             done_meta;  // Lines up with the lane result of the same request

    simd_operand_prep #(.VLEN(VLEN)) u_operand_prep (
        .req_i      (req_i),
        .lane_ops_o (lane_ops),
        .lat_o      (lat),
        .meta_o     (meta)
    );

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        simd_lane u_lane (
            .clk_i    (clk_i),
            .rstn_i   (rstn_i),
            .op_i     (lane_ops[l]),
            .result_o (lane_res[l])
        );
    end

    simd_latency_track #(.VLEN(VLEN)) u_latency_track (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .lat_i       (lat),
        .meta_i      (meta),
        .done_meta_o (done_meta)
    );

    simd_result_stage #(.VLEN(VLEN)) u_result_stage (
        .meta_i      (done_meta),
        .lane_res_i  (lane_res),
        .scalar_wb_o (scalar_wb_o),
        .vector_wb_o (vector_wb_o)
    );

endmodule

//--- src/simd_result_stage.sv
// Result assembly: mask merge, scalar extraction and writeback struct forming
`timescale 1ns/1ps

module simd_result_stage
    import simd_pkg::*;
#(
    parameter int VLEN = 128
) (
    input  simd_meta_t                  meta_i,
    input  elem_word_u [VLEN/LANE_W-1:0] lane_res_i,
    output scalar_wb_t                  scalar_wb_o,
    output vector_wb_t                  vector_wb_o
);

    localparam int LANES = VLEN / LANE_W;

    logic [VLEN-1:0] vres;
    logic [VLEN-1:0] merged;
    logic            is_scalar;
    logic [2:0]      ls;           // log2 of elements per lane
    logic            in_range;
    logic [5:0]      idx;          // At most 64 elements in a register
    elem_word_u      ext_word;
    logic [63:0]     mvxs_val;
    logic [63:0]     ext_val;
    logic [63:0]     scalar_res;

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            vres[l*LANE_W +: LANE_W] = lane_res_i[l];
        end
    end

    // Bit k belongs to element k >> log2(SEW), which picks its mask bit
    always_comb begin
        for (int k = 0; k < VLEN; k++) begin
            if (meta_i.use_mask && !meta_i.vm[k >> (3 + int'(meta_i.sew))]) begin
                merged[k] = meta_i.old_vd[k];
            end else begin
                merged[k] = vres[k];
            end
        end
    end

    assign ls       = 3'd3 - {1'b0, meta_i.sew};
    assign idx      = meta_i.rs1[5:0];
    assign in_range = meta_i.rs1 < 64'(VLEN >> (3 + int'(meta_i.sew)));

    always_comb begin
        ext_word = lane_res_i[0];
        for (int l = 0; l < LANES; l++) begin
            if (l == int'(idx >> ls)) begin
                ext_word = lane_res_i[l];
            end
        end
        case (meta_i.sew)
            SEW_8: begin
                mvxs_val = {{56{lane_res_i[0].b[0][7]}}, lane_res_i[0].b[0]};
                ext_val  = {56'h0, ext_word.b[idx[2:0]]};
            end
            SEW_16: begin
                mvxs_val = {{48{lane_res_i[0].h[0][15]}}, lane_res_i[0].h[0]};
                ext_val  = {48'h0, ext_word.h[idx[1:0]]};
            end
            SEW_32: begin
                mvxs_val = {{32{lane_res_i[0].w[0][31]}}, lane_res_i[0].w[0]};
                ext_val  = {32'h0, ext_word.w[idx[0]]};
            end
            default: begin
                mvxs_val = lane_res_i[0].d;
                ext_val  = ext_word.d;
            end
        endcase
        if (meta_i.op == OP_EXT) begin
            scalar_res = in_range ? ext_val : 64'h0;  // Out-of-range index reads zero
        end else begin
            scalar_res = mvxs_val;
        end
    end

    assign is_scalar = (meta_i.op == OP_MV_X_S) || (meta_i.op == OP_EXT);

    always_comb begin
        scalar_wb_o.valid  = meta_i.valid && is_scalar;
        scalar_wb_o.rd     = meta_i.dst;
        scalar_wb_o.result = scalar_res;

        vector_wb_o.valid              = meta_i.valid && !is_scalar;
        vector_wb_o.vd                 = meta_i.dst;
        vector_wb_o.vresult            = '0;
        vector_wb_o.vresult[VLEN-1:0]  = merged;
    end

endmodule

//--- src/simd_latency_track.sv
// Per-latency delay lines for request metadata and selection of the completing request
`timescale 1ns/1ps

module simd_latency_track
    import simd_pkg::*;
#(
    parameter int VLEN = 128
) (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic [1:0] lat_i,
    input  simd_meta_t meta_i,
    output simd_meta_t done_meta_o
);

    simd_meta_t meta_in;
    logic [2:0] tail_vld;
    simd_meta_t tail_meta [3];

    // Vector bits above VLEN are tied to zero so their flops can be dropped
    always_comb begin
        meta_in                  = meta_i;
        meta_in.vm               = '0;
        meta_in.old_vd           = '0;
        meta_in.vm[VLEN-1:0]     = meta_i.vm[VLEN-1:0];
        meta_in.old_vd[VLEN-1:0] = meta_i.old_vd[VLEN-1:0];
    end

    for (genvar d = 1; d <= 3; d++) begin : g_line
        logic       enter;
        logic [d-1:0] vld_q;
        simd_meta_t meta_q [d];

        assign enter = meta_i.valid && (lat_i == 2'(d));

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                vld_q <= '0;
            end else begin
                vld_q[0] <= enter;
                for (int k = 1; k < d; k++) begin
                    vld_q[k] <= vld_q[k-1];
                end
            end
        end

        always_ff @(posedge clk_i) begin
            meta_q[0] <= meta_in;
            for (int k = 1; k < d; k++) begin
                meta_q[k] <= meta_q[k-1];
            end
        end

        assign tail_vld[d-1]  = vld_q[d-1];
        assign tail_meta[d-1] = meta_q[d-1];
    end

    always_comb begin
        done_meta_o = '0;
        for (int i = 0; i < 3; i++) begin
            if (tail_vld[i]) begin
                done_meta_o       = tail_meta[i];
                done_meta_o.valid = 1'b1;
            end
        end
    end

    // Issuer spaces requests so that no two of them finish together
    assert property (@(posedge clk_i) disable iff (!rstn_i) $onehot0(tail_vld))
        else $error("simd_latency_track: two requests complete in the same cycle");

endmodule

//--- src/simd_lane.sv
// One 64-bit SIMD lane with single-cycle ALU and pipelined element multiplier
`timescale 1ns/1ps

module simd_lane
    import simd_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  lane_op_t   op_i,
    output elem_word_u result_o
);

    logic        is_sub;
    elem_word_u  alu_res;
    elem_word_u  mul_p1;      // Element products, or low partial product at SEW 64
    logic [31:0] cross_p1;    // Sum of the two cross terms for SEW 64

    logic        s1_vld_q;
    sew_e        s1_sew_q;
    elem_word_u  s1_prod_q;
    logic [31:0] s1_cross_q;
    logic        s2_vld_q;
    elem_word_u  s2_prod_q;
    elem_word_u  result_q;

    assign is_sub = (op_i.op == OP_SUB);

    always_comb begin
        alu_res = op_i.a;  // vmv.x.s and vext pass vs2 through
        case (op_i.op)
            OP_ADD, OP_SUB: begin
                case (op_i.sew)
                    SEW_8: begin
                        for (int i = 0; i < 8; i++) begin
                            alu_res.b[i] = is_sub ? op_i.a.b[i] - op_i.b.b[i]
                                                  : op_i.a.b[i] + op_i.b.b[i];
                        end
                    end
                    SEW_16: begin
                        for (int i = 0; i < 4; i++) begin
                            alu_res.h[i] = is_sub ? op_i.a.h[i] - op_i.b.h[i]
                                                  : op_i.a.h[i] + op_i.b.h[i];
                        end
                    end
                    SEW_32: begin
                        for (int i = 0; i < 2; i++) begin
                            alu_res.w[i] = is_sub ? op_i.a.w[i] - op_i.b.w[i]
                                                  : op_i.a.w[i] + op_i.b.w[i];
                        end
                    end
                    default: alu_res.d = is_sub ? op_i.a.d - op_i.b.d : op_i.a.d + op_i.b.d;
                endcase
            end
            OP_AND:  alu_res.d = op_i.a.d & op_i.b.d;
            OP_OR:   alu_res.d = op_i.a.d | op_i.b.d;
            OP_XOR:  alu_res.d = op_i.a.d ^ op_i.b.d;
            default: alu_res = op_i.a;
        endcase
    end

    // Only the low half of each product is kept, so narrow multiplies suffice
    always_comb begin
        mul_p1   = '0;
        cross_p1 = '0;
        case (op_i.sew)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    mul_p1.b[i] = op_i.a.b[i] * op_i.b.b[i];
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    mul_p1.h[i] = op_i.a.h[i] * op_i.b.h[i];
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    mul_p1.w[i] = op_i.a.w[i] * op_i.b.w[i];
                end
            end
            default: begin
                mul_p1.d = 64'(op_i.a.w[0]) * 64'(op_i.b.w[0]);
                cross_p1 = op_i.a.w[0] * op_i.b.w[1] + op_i.a.w[1] * op_i.b.w[0];
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_vld_q <= 1'b0;
            s1_sew_q <= SEW_8;
            s2_vld_q <= 1'b0;
        end else begin
            s1_vld_q <= (op_i.op == OP_MUL);
            s1_sew_q <= op_i.sew;
            s2_vld_q <= s1_vld_q && (s1_sew_q == SEW_64);
        end
    end

    always_ff @(posedge clk_i) begin
        s1_prod_q    <= mul_p1;
        s1_cross_q   <= cross_p1;
        s2_prod_q.d  <= s1_prod_q.d + {s1_cross_q, 32'h0};
        if (s2_vld_q) begin
            result_q <= s2_prod_q;                      // SEW 64 multiply, third stage
        end else if (s1_vld_q && (s1_sew_q != SEW_64)) begin
            result_q <= s1_prod_q;
        end else begin
            result_q <= alu_res;
        end
    end

    assign result_o = result_q;

endmodule

//--- src/simd_operand_prep.sv
// Operand preparation: scalar/immediate replication, lane slicing and latency decode
`timescale 1ns/1ps

module simd_operand_prep
    import simd_pkg::*;
#(
    parameter int VLEN = 128
) (
    input  simd_req_t                 req_i,
    output lane_op_t [VLEN/LANE_W-1:0] lane_ops_o,
    output logic [1:0]                lat_o,
    output simd_meta_t                meta_o
);

    localparam int LANES = VLEN / LANE_W;

    logic [63:0] imm_ext;
    logic [63:0] scalar;
    elem_word_u  rep;        // Scalar replicated at SEW, same for every lane

    assign imm_ext = {{59{req_i.imm5[4]}}, req_i.imm5};
    assign scalar  = (req_i.src == SRC_VX) ? req_i.rs1 : imm_ext;

    always_comb begin
        case (req_i.sew)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    rep.b[i] = scalar[7:0];
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    rep.h[i] = scalar[15:0];
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    rep.w[i] = scalar[31:0];
                end
            end
            default: rep.d = scalar;
        endcase
    end

    // Idle cycles show a logic op to the lanes so no multiply gets started
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            lane_ops_o[l].op  = req_i.valid ? req_i.op : OP_AND;
            lane_ops_o[l].sew = req_i.sew;
            lane_ops_o[l].a   = elem_word_u'(req_i.vs2[l*LANE_W +: LANE_W]);
            lane_ops_o[l].b   = (req_i.src == SRC_VV) ?
                                elem_word_u'(req_i.vs1[l*LANE_W +: LANE_W]) : rep;
        end
    end

    always_comb begin
        if (req_i.op == OP_MUL) begin
            lat_o = (req_i.sew == SEW_64) ? 2'd3 : 2'd2;  // Extra stage for the 64-bit sum
        end else begin
            lat_o = 2'd1;
        end
    end

    always_comb begin
        meta_o.valid    = req_i.valid;
        meta_o.op       = req_i.op;
        meta_o.sew      = req_i.sew;
        meta_o.use_mask = req_i.use_mask;
        meta_o.dst      = req_i.vd;
        meta_o.rs1      = req_i.rs1;
        meta_o.vm       = req_i.vm;
        meta_o.old_vd   = req_i.old_vd;
    end

    // There is no vmul.vi form, the issuer must never send one
    always_comb begin
        if (req_i.valid) begin
            assert (!(req_i.src == SRC_VI && req_i.op == OP_MUL))
                else $error("simd_operand_prep: multiply issued with immediate source");
        end
    end

endmodule

//--- src/simd_pkg.sv
// Shared widths, opcode and SEW enums, lane word union and request/writeback structs
package simd_pkg;

    localparam int LANE_W   = 64;   // Width of one SIMD lane
    localparam int MAX_VLEN = 512;  // Upper bound for the VLEN parameter

    // Element width of a request
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

    typedef enum logic [2:0] {
        OP_ADD    = 3'd0,
        OP_SUB    = 3'd1,
        OP_AND    = 3'd2,
        OP_OR     = 3'd3,
        OP_XOR    = 3'd4,
        OP_MUL    = 3'd5,  // Low half of the element product
        OP_MV_X_S = 3'd6,  // Element 0 to scalar, sign-extended
        OP_EXT    = 3'd7   // Element rs1 to scalar, zero-extended
    } simd_op_e;

    // Source of the second operand
    typedef enum logic [1:0] {
        SRC_VV = 2'd0,
        SRC_VX = 2'd1,
        SRC_VI = 2'd2
    } src_e;

    // One lane word seen at each element width
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } elem_word_u;

    typedef struct packed {
        simd_op_e   op;
        sew_e       sew;
        elem_word_u a;   // vs2 slice
        elem_word_u b;   // vs1 slice or replicated scalar
    } lane_op_t;

    // Request fields that ride along the latency delay lines
    typedef struct packed {
        logic                valid;
        simd_op_e            op;
        sew_e                sew;
        logic                use_mask;
        logic [4:0]          dst;
        logic [63:0]         rs1;
        logic [MAX_VLEN-1:0] vm;
        logic [MAX_VLEN-1:0] old_vd;
    } simd_meta_t;

    typedef struct packed {
        logic                valid;
        simd_op_e            op;
        src_e                src;
        sew_e                sew;
        logic                use_mask;
        logic [4:0]          vd;
        logic [63:0]         rs1;
        logic [4:0]          imm5;
        logic [MAX_VLEN-1:0] vs1;
        logic [MAX_VLEN-1:0] vs2;
        logic [MAX_VLEN-1:0] vm;      // One mask bit per element
        logic [MAX_VLEN-1:0] old_vd;
    } simd_req_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [63:0] result;
    } scalar_wb_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          vd;
        logic [MAX_VLEN-1:0] vresult;  // Bits above VLEN read as zero
    } vector_wb_t;

endpackage
